// ==== list.f ====
+incdir+src
src/clusterPkg.sv
src/taskScheduler.sv
src/computeCore.sv
src/coreCluster.sv
testbench/coreClusterTb.sv

// ==== run.sh ====
#!/bin/bash
# Build and run the cluster testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
SIM=coreClusterSim

verilator --binary --timing --assert -Wno-fatal \
	-f list.f --top-module coreClusterTb -o "$SIM"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/"$SIM" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation run returned status $status"
	exit 1
fi

grep -q "Simulation failed" "$LOG"
if [ $? -eq 0 ]; then
	exit 1
fi

exit 0

// ==== src/clusterPkg.sv ====
`include "clusterSettings_settings.svh"

package clusterPkg;

	typedef logic [`NUM_CORES-1:0] coreVecT;                  // One bit per core
	typedef logic [`REG_WIDTH-1:0] regT;
	typedef logic [`NUM_CORES*`REG_WIDTH-1:0] regBankT;       // Core 0 in low bits
	typedef logic [`FRAME_WIDTH-1:0] frameT;
	typedef logic [$clog2(`TASK_MEM_DEPTH)-1:0] taskPtrT;
	typedef logic [`FRAME_COUNT_WIDTH-1:0] frameCountT;

	typedef enum logic [1:0] {
		fenceNo = 2'd0,    // Wait only for the chosen cores
		fenceAcq = 2'd1,   // Next control frame waits for all cores
		fenceRel = 2'd2    // This frame waits for all cores
	} fenceT;

	typedef enum logic [1:0] {
		opAdd = 2'd0,
		opSub = 2'd1,
		opXor = 2'd2,
		opMul = 2'd3
	} opcodeT;

	localparam int CtrlSpareWidth = `FRAME_WIDTH - 3 - 2 * `NUM_CORES
		- `FRAME_COUNT_WIDTH - `NUM_CORES * `REG_WIDTH;
	localparam int InsnPadWidth = `FRAME_WIDTH - 3 - `REG_WIDTH;

	typedef struct packed {
		logic isControl;                    // Set for control frames
		fenceT fence;
		coreVecT activeCores;
		coreVecT r0Cores;                   // Cores whose R0 is seeded
		frameCountT frameCount;             // Instruction frames that follow
		regBankT r0Values;
		logic [CtrlSpareWidth-1:0] spare;
	} controlFrameT;

	typedef struct packed {
		logic isControl;                    // Clear for instructions
		opcodeT opcode;
		regT operand;
		logic [InsnPadWidth-1:0] padding;
	} insnFrameT;

endpackage

// ==== src/clusterSettings_settings.svh ====
`ifndef CLUSTER_SETTINGS_SVH
`define CLUSTER_SETTINGS_SVH

// Cluster dimensions

`define NUM_CORES 4             // Cores in the cluster

`define TASK_MEM_DEPTH 16       // Frames held in task memory

`define REG_WIDTH 8             // Core register width

`define FRAME_WIDTH 48          // Raw task memory frame

`define FRAME_COUNT_WIDTH 4     // Instruction frames per control frame

`endif

// ==== src/computeCore.sv ====
`include "clusterSettings_settings.svh"

module computeCore (
	input logic clk,
	input logic reset,
	input logic start,
	input clusterPkg::frameT frameBus,
	input logic initR0,
	input clusterPkg::regT initR0Value,
	output logic ready,
	output clusterPkg::regT r0
);

	localparam logic [1:0] AluBusy = 2'd1;   // Add, sub, xor
	localparam logic [1:0] MulBusy = 2'd3;

	clusterPkg::insnFrameT insn;
	clusterPkg::regT result;
	logic [1:0] busyTime;
	logic [1:0] busyCount;

	assign insn = frameBus;
	assign ready = (busyCount == '0);

	always_comb begin
		case (insn.opcode)
			clusterPkg::opAdd: result = r0 + insn.operand;
			clusterPkg::opSub: result = r0 - insn.operand;
			clusterPkg::opXor: result = r0 ^ insn.operand;
			clusterPkg::opMul: result = r0 * insn.operand;   // Low byte kept
			default: result = r0;
		endcase
	end

	assign busyTime = (insn.opcode == clusterPkg::opMul) ? MulBusy : AluBusy;

	always_ff @(posedge clk) begin
		if (reset) begin
			busyCount <= '0;
		end else if (start && !insn.isControl) begin
			busyCount <= busyTime;
		end else if (busyCount != '0) begin
			busyCount <= busyCount - 1'b1;
		end
	end

	// Control frames only seed R0 and never make the core busy
	always_ff @(posedge clk) begin
		if (reset) begin
			r0 <= '0;
		end else if (start) begin
			if (!insn.isControl) begin
				r0 <= result;
			end else if (initR0) begin
				r0 <= initR0Value;
			end
		end
	end

endmodule

// ==== src/coreCluster.sv ====
`include "clusterSettings_settings.svh"

module coreCluster (
	input logic clk,
	input logic reset,
	input clusterPkg::frameT [`TASK_MEM_DEPTH-1:0] taskImage,
	output clusterPkg::coreVecT start,
	output clusterPkg::frameT frameBus,
	output clusterPkg::coreVecT ready,
	output clusterPkg::regBankT coreRegs
);

	clusterPkg::coreVecT initR0;
	clusterPkg::regBankT initR0Values;   // Seed values, one slice per core

	taskScheduler i_taskScheduler (
		.clk(clk),
		.reset(reset),
		.taskImage(taskImage),
		.ready(ready),
		.start(start),
		.frameBus(frameBus),
		.initR0(initR0),
		.initR0Values(initR0Values)
	);

	for (genvar i = 0; i < `NUM_CORES; i++) begin : gCore
		computeCore i_computeCore (
			.clk(clk),
			.reset(reset),
			.start(start[i]),
			.frameBus(frameBus),            // Broadcast to every core
			.initR0(initR0[i]),
			.initR0Value(initR0Values[i*`REG_WIDTH +: `REG_WIDTH]),
			.ready(ready[i]),
			.r0(coreRegs[i*`REG_WIDTH +: `REG_WIDTH])
		);
	end

endmodule

// ==== src/taskScheduler.sv ====
`include "clusterSettings_settings.svh"

module taskScheduler (
	input logic clk,
	input logic reset,
	input clusterPkg::frameT [`TASK_MEM_DEPTH-1:0] taskImage,
	input clusterPkg::coreVecT ready,
	output clusterPkg::coreVecT start,
	output clusterPkg::frameT frameBus,
	output clusterPkg::coreVecT initR0,
	output clusterPkg::regBankT initR0Values
);

	localparam clusterPkg::taskPtrT LastEntry = clusterPkg::taskPtrT'(`TASK_MEM_DEPTH - 1);

	clusterPkg::frameT taskMem [`TASK_MEM_DEPTH];
	clusterPkg::taskPtrT taskPtr;
	clusterPkg::frameCountT frameCount;       // Instruction frames still to issue
	clusterPkg::fenceT fence;                 // Fence left by the last control frame
	clusterPkg::coreVecT activeCores;
	logic settle;                             // Frame just started and pointer moves on

	clusterPkg::frameT curFrame;
	clusterPkg::controlFrameT ctrlFrame;
	clusterPkg::coreVecT busy;
	logic allIdle;
	logic nextIdle;
	logic activeIdle;
	logic fenceOpen;
	logic launch;
	logic issue;

	// Whole memory is refreshed while the pointer sits at the last entry
	always_ff @(posedge clk) begin
		if (taskPtr == LastEntry) begin
			for (int i = 0; i < `TASK_MEM_DEPTH; i++) begin
				taskMem[i] <= taskImage[i];
			end
		end
	end

	assign curFrame = taskMem[taskPtr];
	assign ctrlFrame = curFrame;
	assign frameBus = curFrame;                 // Unregistered so start lines up with it

	assign busy = ~ready;
	assign allIdle = (busy == '0);
	assign nextIdle = ((busy & ctrlFrame.activeCores) == '0);
	assign activeIdle = ((busy & activeCores) == '0);

	assign fenceOpen = (allIdle && (fence == clusterPkg::fenceAcq
		|| ctrlFrame.fence == clusterPkg::fenceRel))
		|| (nextIdle && fence == clusterPkg::fenceNo);

	assign launch = !settle && (frameCount == '0) && fenceOpen;   // Control frame
	assign issue = !settle && (frameCount != '0) && activeIdle;   // Instruction frame

	always_ff @(posedge clk) begin
		if (reset) begin
			start <= '0;
			initR0 <= '0;
			settle <= 1'b0;
		end else begin
			settle <= launch || issue;
			if (launch) begin
				start <= ctrlFrame.activeCores;
				initR0 <= ctrlFrame.r0Cores;
			end else if (issue) begin
				start <= activeCores;
				initR0 <= '0;
			end else begin
				start <= '0;
				initR0 <= '0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (launch) begin
			initR0Values <= ctrlFrame.r0Values;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			taskPtr <= LastEntry;                 // Forces a reload first
		end else if (settle) begin
			taskPtr <= (taskPtr == LastEntry) ? '0 : taskPtr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			frameCount <= clusterPkg::frameCountT'(1);   // Stale entry counts as last insn
		end else if (launch) begin
			frameCount <= ctrlFrame.frameCount;
		end else if (issue) begin
			frameCount <= frameCount - 1'b1;
		end
	end

	// Release acts on its own frame only, so it is not kept
	always_ff @(posedge clk) begin
		if (reset) begin
			fence <= clusterPkg::fenceNo;
		end else if (launch) begin
			fence <= (ctrlFrame.fence == clusterPkg::fenceAcq) ?
				clusterPkg::fenceAcq : clusterPkg::fenceNo;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			activeCores <= '0;
		end else if (launch) begin
			activeCores <= ctrlFrame.activeCores;
		end
	end

endmodule

// ==== testbench/coreClusterTb.sv ====
`include "clusterSettings_settings.svh"

module coreClusterTb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int ClkPeriod = 40;
	localparam int ResetCycles = 5;
	localparam int WorstBusy = 3;                       // Multiply
	localparam int FrameCycles = WorstBusy + 4;         // Busy time plus scheduler overhead
	localparam int WatchdogCycles = 2 * `TASK_MEM_DEPTH * FrameCycles + ResetCycles + 40;

	logic clk;
	logic reset;
	clusterPkg::frameT [`TASK_MEM_DEPTH-1:0] taskImage;
	clusterPkg::coreVecT start;
	clusterPkg::frameT frameBus;
	clusterPkg::coreVecT ready;
	clusterPkg::regBankT coreRegs;

	int seed;
	int errors = 0;
	int checks = 0;
	int pulseCount = 0;                                 // Start pulses since reset

	clusterPkg::regT expR0 [`NUM_CORES];
	clusterPkg::coreVecT lastActive;                    // From the latest control frame
	logic acqPending;                                   // Last control frame was an acquire
	clusterPkg::controlFrameT ctrlView;
	clusterPkg::insnFrameT insnView;
	clusterPkg::regT seedValue;

	coreCluster i_coreCluster (
		.clk(clk),
		.reset(reset),
		.taskImage(taskImage),
		.start(start),
		.frameBus(frameBus),
		.ready(ready),
		.coreRegs(coreRegs)
	);

	initial begin
		clk = 1'b0;
		forever #(ClkPeriod / 2) clk = ~clk;
	end

	function automatic clusterPkg::frameT controlWord(input clusterPkg::fenceT fence,
		input clusterPkg::coreVecT active, input clusterPkg::coreVecT seedCores, input int count);
		clusterPkg::controlFrameT f;
		f.isControl = 1'b1;
		f.fence = fence;
		f.activeCores = active;
		f.r0Cores = seedCores;
		f.frameCount = clusterPkg::frameCountT'(count);
		for (int i = 0; i < `NUM_CORES; i++) begin
			f.r0Values[i*`REG_WIDTH +: `REG_WIDTH] = clusterPkg::regT'($random(seed));
		end
		f.spare = '0;
		return f;
	endfunction

	function automatic clusterPkg::frameT insnWord(input clusterPkg::opcodeT op);
		clusterPkg::insnFrameT f;
		f.isControl = 1'b0;
		f.opcode = op;
		f.operand = clusterPkg::regT'($random(seed));
		f.padding = '0;
		return f;
	endfunction

	// Accumulator rule with all results modulo 256
	function automatic clusterPkg::regT expectedResult(input clusterPkg::regT acc,
		input clusterPkg::opcodeT op, input clusterPkg::regT operand);
		logic [2*`REG_WIDTH-1:0] product;
		clusterPkg::regT value;
		product = acc * operand;
		case (op)
			clusterPkg::opAdd: value = acc + operand;
			clusterPkg::opSub: value = acc - operand;
			clusterPkg::opXor: value = acc ^ operand;
			default: value = product[`REG_WIDTH-1:0];   // Low byte of the product
		endcase
		return value;
	endfunction

	// Four tasks fill all 16 entries and the last entry is an instruction
	task automatic loadProgram();
		taskImage[0] = controlWord(clusterPkg::fenceNo, 4'b0011, 4'b0011, 3);
		taskImage[1] = insnWord(clusterPkg::opAdd);
		taskImage[2] = insnWord(clusterPkg::opMul);
		taskImage[3] = insnWord(clusterPkg::opSub);
		taskImage[4] = controlWord(clusterPkg::fenceAcq, 4'b1100, 4'b0100, 2);
		taskImage[5] = insnWord(clusterPkg::opXor);
		taskImage[6] = insnWord(clusterPkg::opMul);
		taskImage[7] = controlWord(clusterPkg::fenceRel, 4'b1111, 4'b1000, 3);
		taskImage[8] = insnWord(clusterPkg::opAdd);
		taskImage[9] = insnWord(clusterPkg::opSub);
		taskImage[10] = insnWord(clusterPkg::opXor);
		taskImage[11] = controlWord(clusterPkg::fenceNo, 4'b0101, 4'b0001, 4);
		taskImage[12] = insnWord(clusterPkg::opMul);
		taskImage[13] = insnWord(clusterPkg::opAdd);
		taskImage[14] = insnWord(clusterPkg::opXor);
		taskImage[15] = insnWord(clusterPkg::opSub);
	endtask

	// Reference model and checks sampled mid-cycle
	always @(negedge clk) begin
		if (reset) begin
			for (int i = 0; i < `NUM_CORES; i++) begin
				expR0[i] = '0;
			end
			lastActive = '0;
			acqPending = 1'b0;
			pulseCount = 0;
		end else begin
			ctrlView = frameBus;
			insnView = frameBus;
			for (int i = 0; i < `NUM_CORES; i++) begin
				if (start[i]) begin
					checks++;
					assert (ready[i]) else begin
						errors++;
						$display("Error at %0t: start[%0d] pulsed while core %0d is busy",
							$time, i, i);
					end
				end
				if (ready[i]) begin
					checks++;
					assert (coreRegs[i*`REG_WIDTH +: `REG_WIDTH] == expR0[i]) else begin
						errors++;
						$display("Error at %0t: coreRegs[%0d] = %h, expected %h", $time, i,
							coreRegs[i*`REG_WIDTH +: `REG_WIDTH], expR0[i]);
					end
				end
			end
			if (start != '0) begin
				checks++;
				assert (frameBus == taskImage[pulseCount % `TASK_MEM_DEPTH]) else begin
					errors++;
					$display("Error at %0t: frameBus = %h, expected %h", $time, frameBus,
						taskImage[pulseCount % `TASK_MEM_DEPTH]);
				end
				pulseCount++;
				if (ctrlView.isControl) begin
					checks++;
					assert (start == ctrlView.activeCores) else begin
						errors++;
						$display("Error at %0t: start = %b, expected %b", $time, start,
							ctrlView.activeCores);
					end
					if (ctrlView.fence == clusterPkg::fenceRel || acqPending) begin
						checks++;
						assert (ready == '1) else begin
							errors++;
							$display("Error at %0t: ready = %b, expected %b", $time, ready,
								4'b1111);
						end
					end
					acqPending = (ctrlView.fence == clusterPkg::fenceAcq);
					lastActive = ctrlView.activeCores;
					for (int i = 0; i < `NUM_CORES; i++) begin
						seedValue = ctrlView.r0Values[i*`REG_WIDTH +: `REG_WIDTH];
						if (start[i] && ctrlView.r0Cores[i]) begin
							expR0[i] = seedValue;
						end
					end
				end else begin
					checks++;
					assert (start == lastActive) else begin
						errors++;
						$display("Error at %0t: start = %b, expected %b", $time, start, lastActive);
					end
					for (int i = 0; i < `NUM_CORES; i++) begin
						if (start[i]) begin
							expR0[i] = expectedResult(expR0[i], insnView.opcode, insnView.operand);
						end
					end
				end
			end
		end
	end

	initial begin
		#(WatchdogCycles * ClkPeriod);
		$display("Timeout: two program passes did not finish within %0d cycles", WatchdogCycles);
		$display("Checks: %0d, errors: %0d", checks, errors + 1);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		seed = 65928;
		reset = 1'b1;
		loadProgram();
		repeat (ResetCycles) @(negedge clk);
		checks++;
		assert (start == '0) else begin
			errors++;
			$display("Error at %0t: start = %b, expected %b", $time, start, 4'b0000);
		end
		checks++;
		assert (ready == '1) else begin
			errors++;
			$display("Error at %0t: ready = %b, expected %b", $time, ready, 4'b1111);
		end
		checks++;
		assert (coreRegs == '0) else begin
			errors++;
			$display("Error at %0t: coreRegs = %h, expected %h", $time, coreRegs, 32'h0);
		end
		reset <= 1'b0;
		while (pulseCount < 2 * `TASK_MEM_DEPTH) @(posedge clk);   // Two full passes
		@(negedge clk);
		while (ready != '1) @(negedge clk);                        // Last results checked
		@(posedge clk);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule
